/* list.f */
source/organ_pkg.sv
source/tone_generator.sv
source/key_repeat.sv
source/speed_register.sv
source/hex_display.sv
source/organ_top.sv
sim/tb_organ_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the organ testbench with Verilator
set -e
rm -rf obj_dir
verilator --binary --timing --top-module tb_organ_top -f list.f
./obj_dir/Vtb_organ_top > sim.log 2>&1
cat sim.log
if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

/* sim/tb_organ_top.sv */
`timescale 1ns/1ns

module tb_organ_top;

  localparam int key_tick_div  = 4;
  localparam int repeat_ticks  = 3;
  localparam int display_div   = 16;
  localparam int repeat_cycles = (repeat_ticks + 1) * key_tick_div;

  // Active-low hex segments 0 to F, bit 0 is segment a
  localparam logic [6:0] seg_table [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic        CLK_50M;
  logic        reset;
  logic [3:0]  sw;
  logic [2:0]  key;
  logic [7:0]  audio_sample;
  logic [15:0] scope_sample_count;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;

  int error_count;
  int cycle_count;
  int cycle_limit;
  int seed;

  organ_top #(
    .key_tick_div (key_tick_div),
    .repeat_ticks (repeat_ticks),
    .display_div  (display_div)
  ) u_organ_top (
    .CLK_50M            (CLK_50M),
    .reset              (reset),
    .sw                 (sw),
    .key                (key),
    .audio_sample       (audio_sample),
    .scope_sample_count (scope_sample_count),
    .hex0               (hex0),
    .hex1               (hex1),
    .hex2               (hex2),
    .hex3               (hex3),
    .hex4               (hex4),
    .hex5               (hex5)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Cycle budget from the note periods plus the enable-off run
  initial
  begin
    cycle_count = 0;
    cycle_limit = 100000;
    for (int i = 0; i < organ_pkg::note_count; i++)
      cycle_limit = cycle_limit + 6 * int'(organ_pkg::note_half_period[i]);
    while (cycle_count < cycle_limit)
    begin
      @(posedge CLK_50M);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

  // ====================
  // Helpers
  // ====================

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAILED t=%0t %s: got %0h expected %0h", $time, name, got, exp);
    error_count++;
  endtask

  task automatic check_display(input logic [15:0] value);
    logic [23:0] word;
    logic [41:0] exp_segs;
    logic [41:0] got_segs;
    word = {8'h00, value};
    for (int i = 0; i < 6; i++)
      exp_segs[7*i +: 7] = seg_table[word[4*i +: 4]];
    got_segs = {hex5, hex4, hex3, hex2, hex1, hex0};
    if (got_segs !== exp_segs)
      report_mismatch("hex5..hex0", 64'(got_segs), 64'(exp_segs));
  endtask

  // Waits for a low-to-high step of the sample, returns the cycles taken
  task automatic wait_rise(output int cycles);
    logic [7:0] prev;
    logic       seen;
    cycles = 0;
    seen   = 1'b0;
    prev   = audio_sample;
    while (!seen)
    begin
      @(negedge CLK_50M);
      cycles++;
      if (audio_sample !== organ_pkg::sample_high && audio_sample !== organ_pkg::sample_low)
        report_mismatch("audio_sample code", 64'(audio_sample), 64'(organ_pkg::sample_low));
      if (prev == organ_pkg::sample_low && audio_sample == organ_pkg::sample_high)
        seen = 1'b1;
      prev = audio_sample;
    end
  endtask

  task automatic wait_count_change(input int limit);
    logic [15:0] start;
    int          n;
    start = scope_sample_count;
    n     = 0;
    while (scope_sample_count === start && n < limit)
    begin
      @(negedge CLK_50M);
      n++;
    end
    if (scope_sample_count === start)
    begin
      $display("scope_sample_count did not change within %0d cycles of a key press", limit);
      error_count++;
    end
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic test_reset_state();
    if (audio_sample !== organ_pkg::sample_low)
      report_mismatch("audio_sample", 64'(audio_sample), 64'(organ_pkg::sample_low));
    if (scope_sample_count !== organ_pkg::default_sample_count)
      report_mismatch("scope_sample_count", 64'(scope_sample_count),
                      64'(organ_pkg::default_sample_count));
    check_display(16'h0000);
    repeat (display_div + 2) @(negedge CLK_50M);
    check_display(organ_pkg::default_sample_count);
  endtask

  task automatic test_note_periods();
    logic [2:0] note_order [8];
    logic [2:0] tmp;
    int         j;
    int         cycles;
    int         exp_period;
    for (int i = 0; i < 8; i++)
      note_order[i] = 3'(i);
    // Shuffle the visiting order
    for (int i = 7; i > 0; i--)
    begin
      j = {$random(seed)} % (i + 1);
      tmp = note_order[i];
      note_order[i] = note_order[j];
      note_order[j] = tmp;
    end
    for (int i = 0; i < 8; i++)
    begin
      sw = {note_order[i], 1'b1};
      exp_period = 2 * int'(organ_pkg::note_half_period[note_order[i]]);
      // First period after the switch may be short
      wait_rise(cycles);
      wait_rise(cycles);
      if (cycles != exp_period)
        report_mismatch("audio_sample period", 64'(cycles), 64'(exp_period));
    end
  endtask

  task automatic test_enable_off();
    logic failed;
    failed = 1'b0;
    for (int seg_run = 0; seg_run < 4; seg_run++)
    begin
      sw = {3'($random(seed)), 1'b0};
      for (int n = 0; n < 25000 && !failed; n++)
      begin
        @(negedge CLK_50M);
        if (audio_sample !== organ_pkg::sample_low)
        begin
          report_mismatch("audio_sample", 64'(audio_sample), 64'(organ_pkg::sample_low));
          failed = 1'b1;
        end
      end
    end
  endtask

  task automatic test_single_steps();
    logic [15:0] exp_up;
    exp_up = organ_pkg::default_sample_count + organ_pkg::speed_step;
    key = 3'b110;
    wait_count_change(repeat_cycles + 8);
    key = 3'b111;
    if (scope_sample_count !== exp_up)
      report_mismatch("scope_sample_count", 64'(scope_sample_count), 64'(exp_up));
    repeat (display_div + 2) @(negedge CLK_50M);
    check_display(exp_up);
    key = 3'b101;
    wait_count_change(repeat_cycles + 8);
    key = 3'b111;
    if (scope_sample_count !== organ_pkg::default_sample_count)
      report_mismatch("scope_sample_count", 64'(scope_sample_count),
                      64'(organ_pkg::default_sample_count));
    repeat (display_div + 2) @(negedge CLK_50M);
    check_display(organ_pkg::default_sample_count);
  endtask

  task automatic test_repeat_clear();
    int   diff;
    int   n;
    logic cleared;
    key = 3'b110;
    repeat (20 * repeat_cycles) @(negedge CLK_50M);
    diff = int'(scope_sample_count) - int'(organ_pkg::default_sample_count);
    if (diff % 100 != 0 || diff < 19 * 100 || diff > 21 * 100)
      report_mismatch("scope_sample_count", 64'(scope_sample_count),
                      64'(organ_pkg::default_sample_count + 16'd2000));
    // Clear while the up key stays held
    key = 3'b010;
    cleared = 1'b0;
    for (n = 0; n < 4 && !cleared; n++)
    begin
      @(negedge CLK_50M);
      if (scope_sample_count === organ_pkg::default_sample_count)
        cleared = 1'b1;
    end
    if (!cleared)
    begin
      $display("scope_sample_count was not cleared within 4 cycles of the clear key");
      error_count++;
    end
    repeat (3 * repeat_cycles)
    begin
      @(negedge CLK_50M);
      if (scope_sample_count !== organ_pkg::default_sample_count)
        report_mismatch("scope_sample_count", 64'(scope_sample_count),
                        64'(organ_pkg::default_sample_count));
    end
    key = 3'b111;
  endtask

  // ====================
  // Main sequence
  // ====================

  initial
  begin
    seed        = 11;
    error_count = 0;
    sw          = 4'b0000;
    key         = 3'b111;
    reset       = 1'b1;
    repeat (5) @(negedge CLK_50M);
    reset = 1'b0;
    @(negedge CLK_50M);

    test_reset_state();
    test_note_periods();
    test_enable_off();
    test_single_steps();
    test_repeat_clear();

    $display("Errors: %0d", error_count);
    if (error_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* source/hex_display.sv */
`timescale 1ns/1ns

module hex_display #(
  parameter int display_div = 25000000
) (
  input  logic        CLK_50M,
  input  logic        reset,
  input  logic [15:0] display_value,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  localparam int refresh_w = $clog2(display_div + 1);

  logic [refresh_w-1:0]  refresh_count;
  logic                  refresh_tick;
  organ_pkg::hex_word_u  shown;
  logic [6:0]            seg [organ_pkg::digit_count];

  // Active-low segments, bit 0 is segment a
  function automatic logic [6:0] seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_decode = 7'b1000000;
      4'h1: seg_decode = 7'b1111001;
      4'h2: seg_decode = 7'b0100100;
      4'h3: seg_decode = 7'b0110000;
      4'h4: seg_decode = 7'b0011001;
      4'h5: seg_decode = 7'b0010010;
      4'h6: seg_decode = 7'b0000010;
      4'h7: seg_decode = 7'b1111000;
      4'h8: seg_decode = 7'b0000000;
      4'h9: seg_decode = 7'b0010000;
      4'hA: seg_decode = 7'b0001000;
      4'hB: seg_decode = 7'b0000011;
      4'hC: seg_decode = 7'b1000110;
      4'hD: seg_decode = 7'b0100001;
      4'hE: seg_decode = 7'b0000110;
      default: seg_decode = 7'b0001110;
    endcase
  endfunction

  // ====================
  // Refresh and latch
  // ====================

  assign refresh_tick = (refresh_count == refresh_w'(display_div - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      refresh_count <= '0;
      shown.value   <= '0;
    end
    else
    begin
      refresh_count <= refresh_tick ? '0 : refresh_count + 1'b1;
      if (refresh_tick)
        shown.value <= {8'h00, display_value};
    end
  end

  // ====================
  // Segment decoders
  // ====================

  always_comb
  begin
    for (int i = 0; i < organ_pkg::digit_count; i++)
      seg[i] = seg_decode(shown.digit[i]);
  end

  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

endmodule

/* source/key_repeat.sv */
`timescale 1ns/1ns

module key_repeat #(
  parameter int key_tick_div = 50000,
  parameter int repeat_ticks = 100
) (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic [2:0] key,
  output logic       step_up,
  output logic       step_down,
  output logic       speed_clear
);

  localparam int tick_w   = $clog2(key_tick_div + 1);
  localparam int repeat_w = $clog2(repeat_ticks + 1);

  logic [2:0]          key_meta;
  logic [2:0]          key_sync;
  logic [tick_w-1:0]   tick_count;
  logic                key_tick;
  logic [repeat_w-1:0] repeat_count;
  logic                repeat_due;

  // ====================
  // Key synchronizers
  // ====================

  // Keys are active low, so invert on the way in
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key;
      key_sync <= key_meta;
    end
  end

  // Clear acts on the level, no rate limit
  assign speed_clear = key_sync[2];

  // ====================
  // Key tick and repeat
  // ====================

  assign key_tick   = (tick_count == tick_w'(key_tick_div - 1));
  assign repeat_due = key_tick && (repeat_count == repeat_w'(repeat_ticks));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tick_count   <= '0;
      repeat_count <= '0;
      step_up      <= 1'b0;
      step_down    <= 1'b0;
    end
    else
    begin
      tick_count <= key_tick ? '0 : tick_count + 1'b1;

      if (repeat_due)
        repeat_count <= '0;
      else if (key_tick)
        repeat_count <= repeat_count + 1'b1;

      // One pulse per held key on each repeat boundary
      step_up   <= repeat_due && key_sync[0];
      step_down <= repeat_due && key_sync[1];
    end
  end

endmodule

/* source/organ_pkg.sv */
package organ_pkg;

  // ====================
  // Tone table
  // ====================

  localparam int note_count = 8;

  // Half-period counts at 50 MHz, indexed by note select
  localparam logic [31:0] note_half_period [note_count] = '{
    32'd47800,
    32'd42590,
    32'd37936,
    32'd35817,
    32'd31929,
    32'd28409,
    32'd25329,
    32'd23900
  };

  // Signed 8-bit sample codes
  localparam logic [7:0] sample_high = 8'h7F;
  localparam logic [7:0] sample_low  = 8'h80;

  // ====================
  // Sampling rate
  // ====================

  localparam logic [15:0] speed_step           = 16'd100;
  localparam logic [15:0] default_sample_count = 16'd12499;

  // ====================
  // Display
  // ====================

  localparam int digit_count = 6;

  // One display word, seen whole or as hex digits (digit 0 is the low nibble)
  typedef union packed {
    logic [23:0]                      value;
    logic [digit_count-1:0][3:0]      digit;
  } hex_word_u;

endpackage

/* source/organ_top.sv */
`timescale 1ns/1ns

module organ_top #(
  parameter int key_tick_div = 50000,
  parameter int repeat_ticks = 100,
  parameter int display_div  = 25000000
) (
  input  logic        CLK_50M,
  input  logic        reset,
  input  logic [3:0]  sw,
  input  logic [2:0]  key,
  output logic [7:0]  audio_sample,
  output logic [15:0] scope_sample_count,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  logic step_up;
  logic step_down;
  logic speed_clear;

  // ====================
  // Tone path
  // ====================

  // sw[0] enables, sw[3:1] picks the note
  tone_generator u_tone_generator (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .tone_enable  (sw[0]),
    .note_select  (sw[3:1]),
    .audio_sample (audio_sample)
  );

  // ====================
  // Speed control
  // ====================

  key_repeat #(
    .key_tick_div (key_tick_div),
    .repeat_ticks (repeat_ticks)
  ) u_key_repeat (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .key         (key),
    .step_up     (step_up),
    .step_down   (step_down),
    .speed_clear (speed_clear)
  );

  speed_register u_speed_register (
    .CLK_50M            (CLK_50M),
    .reset              (reset),
    .step_up            (step_up),
    .step_down          (step_down),
    .speed_clear        (speed_clear),
    .scope_sample_count (scope_sample_count)
  );

  // Count shown in hex at the refresh rate
  hex_display #(
    .display_div (display_div)
  ) u_hex_display (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .display_value (scope_sample_count),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

endmodule

/* source/speed_register.sv */
`timescale 1ns/1ns

module speed_register (
  input  logic        CLK_50M,
  input  logic        reset,
  input  logic        step_up,
  input  logic        step_down,
  input  logic        speed_clear,
  output logic [15:0] scope_sample_count
);

  // Signed offset from the default count, wraps modulo 2^16
  logic signed [15:0] offset;

  // ====================
  // Offset register
  // ====================

  // Clear wins over up, up wins over down
  always_ff @(posedge CLK_50M)
  begin
    if (reset || speed_clear)
    begin
      offset <= '0;
    end
    else if (step_up)
    begin
      offset <= offset + organ_pkg::speed_step;
    end
    else if (step_down)
    begin
      offset <= offset - organ_pkg::speed_step;
    end
  end

  // ====================
  // Sampling count
  // ====================

  // Follows the offset one cycle later
  always_ff @(posedge CLK_50M)
  begin
    scope_sample_count <= organ_pkg::default_sample_count + offset;
  end

endmodule

/* source/tone_generator.sv */
`timescale 1ns/1ns

module tone_generator (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic       tone_enable,
  input  logic [2:0] note_select,
  output logic [7:0] audio_sample
);

  logic [31:0] half_period;
  logic [31:0] div_count;
  logic        wave;
  logic        div_wrap;

  // Note lookup
  assign half_period = organ_pkg::note_half_period[note_select];

  // Wrap at half period minus one, or above it after a note change
  assign div_wrap = (div_count >= half_period - 32'd1);

  // ====================
  // Half-period divider
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      div_count <= '0;
      wave      <= 1'b0;
    end
    else if (div_wrap)
    begin
      div_count <= '0;
      wave      <= ~wave;
    end
    else
    begin
      div_count <= div_count + 32'd1;
    end
  end

  // ====================
  // Sample output
  // ====================

  // One cycle behind the wave; disabled tone sits at the low code
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      audio_sample <= organ_pkg::sample_low;
    end
    else if (tone_enable && wave)
    begin
      audio_sample <= organ_pkg::sample_high;
    end
    else
    begin
      audio_sample <= organ_pkg::sample_low;
    end
  end

endmodule
